//--- design/serial_link_pkg.sv
// Shared types and constants for the serial link physical and link layer.
// Imported by the interface, the receiver, the transmitter and the top level.

package serial_link_pkg;

  // ----------------------------------------------
  // Frame format
  // ----------------------------------------------

  // Data bytes that follow the tag byte
  localparam int BYTES_PER_FRAME = 8;

  // Receiver byte lanes, one per byte position plus the tag
  localparam int LANES = BYTES_PER_FRAME + 1;

  // Width of the data byte index in both state machines
  localparam int BYTE_IDX_W = $clog2(BYTES_PER_FRAME);

  // Frame tag; only bits 6:0 are significant on the wire
  typedef enum logic [7:0] {
    Idle  = 8'd0,
    TagAW = 8'd1,
    TagW  = 8'd2,
    TagAR = 8'd3,
    TagR  = 8'd4
  } tag_e;

  // Tag occupies the top byte so the tag lane lands at the MSB end
  typedef struct packed {
    tag_e        tag;
    logic [63:0] data;
  } phy_payload_t;

  // ----------------------------------------------
  // Serializer and deframer states
  // ----------------------------------------------
  typedef enum logic {
    PhyIdle,
    PhyBusy
  } phy_state_e;

endpackage

//--- design/payload_stream_if.sv
// Valid/ready stream carrying one link payload between blocks.
// A beat transfers in any cycle where valid and ready are both high.
`timescale 1ns/100ps

interface payload_stream_if;

  import serial_link_pkg::*;

  logic         valid;
  logic         ready;
  phy_payload_t payload;

  // Producer side, payload held while valid and not ready
  modport src (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  payload,
    output ready
  );

endinterface

//--- design/ddr_capture.sv
// Input stage of the 4-bit DDR pin bus. Samples both clock phases and
// presents one whole byte per rising edge, two cycles after it left the pins.
`timescale 1ns/100ps

module ddr_capture (
  input  logic       ddr_clk_i,
  input  logic       rst_ni,
  input  logic [3:0] ddr_i,
  output logic [7:0] rx_byte_o
);

  logic [3:0] ddr_lo_q;
  logic [3:0] ddr_hi_q;
  logic [7:0] ddr_q2;

  // Low nibble is driven during the high phase
  always_ff @(negedge ddr_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ddr_lo_q <= '0;
    end else begin
      ddr_lo_q <= ddr_i;
    end
  end

  // High nibble is driven during the low phase
  always_ff @(posedge ddr_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ddr_hi_q <= '0;
    end else begin
      ddr_hi_q <= ddr_i;
    end
  end

  // Retime the nibble pair so a full byte changes on the rising edge
  always_ff @(negedge ddr_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ddr_q2 <= '0;
    end else begin
      ddr_q2 <= {ddr_hi_q, ddr_lo_q};
    end
  end

  always_ff @(posedge ddr_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_byte_o <= '0;
    end else begin
      rx_byte_o <= ddr_q2;
    end
  end

endmodule

//--- design/frame_receiver.sv
// Link receiver. Deframes the byte stream into nine lane FIFOs, spots
// returned credits in bit 7 and offers a frame once every lane holds a byte.
`timescale 1ns/100ps

module frame_receiver #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic             ddr_clk_i,
  input  logic             rst_ni,
  input  logic [7:0]       rx_byte_i,
  output logic             credit_rcvd_o,
  output logic             frame_popped_o,
  payload_stream_if.src    rx
);

  import serial_link_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  phy_state_e            state_d, state_q;
  logic [BYTE_IDX_W-1:0] index_d, index_q;

  logic [LANES-1:0]      lane_push;
  logic [LANES-1:0]      lane_valid;
  logic [LANES-1:0][7:0] lane_data_out;
  logic                  lane_pop;

  // ----------------------------------------------
  // Deframer
  // ----------------------------------------------
  always_comb begin
    state_d       = state_q;
    index_d       = index_q;
    lane_push     = '0;
    credit_rcvd_o = 1'b0;

    unique case (state_q)
      PhyIdle: begin
        // Any tag value other than Idle opens a frame
        if (rx_byte_i[6:0] != 7'd0) begin
          state_d              = PhyBusy;
          index_d              = '0;
          lane_push[LANES-1]   = 1'b1;
        end
        if (rx_byte_i[7]) begin
          credit_rcvd_o = 1'b1;
        end
      end
      PhyBusy: begin
        index_d   = index_q + 1'b1;
        lane_push = LANES'(1) << index_q;
        if (index_q == BYTE_IDX_W'(BYTES_PER_FRAME - 1)) begin
          state_d = PhyIdle;
        end
      end
      default: state_d = PhyIdle;
    endcase
  end

  always_ff @(posedge ddr_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PhyIdle;
      index_q <= '0;
    end else begin
      state_q <= state_d;
      index_q <= index_d;
    end
  end

  // ----------------------------------------------
  // Lane FIFOs
  // ----------------------------------------------
  for (genvar i = 0; i < LANES; i++) begin : gen_lane
    logic [7:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [7:0]       data_in;

    // Bit 7 of the tag byte is flow control, not payload
    assign data_in = (i == LANES - 1) ? (rx_byte_i & 8'h7F) : rx_byte_i;

    always_ff @(posedge ddr_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (lane_push[i]) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (lane_pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (lane_push[i] && !lane_pop) begin
          count_q <= count_q + 1'b1;
        end else if (!lane_push[i] && lane_pop) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    always_ff @(posedge ddr_clk_i) begin
      if (lane_push[i]) begin
        mem[wr_ptr_q] <= data_in;
      end
    end

    assign lane_valid[i]    = (count_q != '0);
    assign lane_data_out[i] = mem[rd_ptr_q];
  end

  // A frame is ready once every lane has a byte
  assign rx.valid       = &lane_valid;
  assign rx.payload     = phy_payload_t'(lane_data_out);
  assign lane_pop       = rx.valid & rx.ready;
  assign frame_popped_o = lane_pop;

endmodule

//--- design/frame_transmitter.sv
// Link transmitter. Tracks send credits and credits owed to the far side,
// serializes tag plus eight data bytes and drives the 4-bit DDR pins.
`timescale 1ns/100ps

module frame_transmitter #(
  parameter int INIT_CREDITS = 3
) (
  input  logic                        ddr_clk_i,
  input  logic                        rst_ni,
  input  logic                        tx_valid_i,
  input  serial_link_pkg::phy_payload_t tx_payload_i,
  output logic                        tx_ready_o,
  input  logic                        credit_rcvd_i,
  input  logic                        frame_popped_i,
  output logic [3:0]                  ddr_o
);

  import serial_link_pkg::*;

  // Credits are conserved across the link, so INIT_CREDITS bounds both counters
  localparam int CNT_W = $clog2(INIT_CREDITS + 1);

  phy_state_e            state_d, state_q;
  logic [BYTE_IDX_W-1:0] index_d, index_q;
  logic [CNT_W-1:0]      credit_d, credit_q;
  logic [CNT_W-1:0]      to_return_d, to_return_q;
  logic [7:0]            data_out_d, data_out_q;

  // ----------------------------------------------
  // Serializer and credit bookkeeping
  // ----------------------------------------------
  always_comb begin
    state_d     = state_q;
    index_d     = index_q;
    credit_d    = credit_q;
    to_return_d = to_return_q;
    data_out_d  = '0;
    tx_ready_o  = 1'b0;

    unique case (state_q)
      PhyIdle: begin
        if (tx_valid_i && credit_q != '0) begin
          state_d    = PhyBusy;
          index_d    = '0;
          data_out_d = tx_payload_i.tag;
          credit_d   = credit_d - 1'b1;
        end
        // Owed credits ride on idle and tag bytes
        if (to_return_q != '0) begin
          data_out_d[7] = 1'b1;
          to_return_d   = to_return_d - 1'b1;
        end
      end
      PhyBusy: begin
        index_d    = index_q + 1'b1;
        data_out_d = tx_payload_i.data[index_q*8 +: 8];
        if (index_q == BYTE_IDX_W'(BYTES_PER_FRAME - 1)) begin
          state_d    = PhyIdle;
          tx_ready_o = 1'b1;
        end
      end
      default: state_d = PhyIdle;
    endcase

    if (credit_rcvd_i) begin
      credit_d = credit_d + 1'b1;
    end
    if (frame_popped_i) begin
      to_return_d = to_return_d + 1'b1;
    end
  end

  always_ff @(posedge ddr_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= PhyIdle;
      index_q     <= '0;
      credit_q    <= CNT_W'(INIT_CREDITS);
      to_return_q <= '0;
    end else begin
      state_q     <= state_d;
      index_q     <= index_d;
      credit_q    <= credit_d;
      to_return_q <= to_return_d;
    end
  end

  // ----------------------------------------------
  // DDR output
  // ----------------------------------------------
  always_ff @(posedge ddr_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_out_q <= '0;
    end else begin
      data_out_q <= data_out_d;
    end
  end

  // Low nibble in the high phase, high nibble in the low phase
  assign ddr_o = ddr_clk_i ? data_out_q[3:0] : data_out_q[7:4];

endmodule

//--- design/serial_link.sv
// Top level of the serial link PHY. Joins the DDR input stage, the receiver,
// the credit path and the transmitter; payloads enter and leave on plain ports.
`timescale 1ns/100ps

module serial_link #(
  parameter int FIFO_DEPTH   = 4,
  parameter int INIT_CREDITS = 3
) (
  input  logic                  ddr_clk_i,
  input  logic                  rst_ni,

  input  logic                  tx_valid_i,
  input  serial_link_pkg::tag_e tx_tag_i,
  input  logic [63:0]           tx_data_i,
  output logic                  tx_ready_o,

  output logic                  rx_valid_o,
  input  logic                  rx_ready_i,
  output serial_link_pkg::tag_e rx_tag_o,
  output logic [63:0]           rx_data_o,

  input  logic [3:0]            ddr_i,
  output logic [3:0]            ddr_o
);

  import serial_link_pkg::*;

  logic         [7:0] rx_byte;
  logic               credit_rcvd;
  logic               frame_popped;
  phy_payload_t       tx_payload;

  payload_stream_if rx_stream ();

  assign tx_payload = '{tag: tx_tag_i, data: tx_data_i};

  assign rx_valid_o      = rx_stream.valid;
  assign rx_stream.ready = rx_ready_i;
  assign rx_tag_o        = rx_stream.payload.tag;
  assign rx_data_o       = rx_stream.payload.data;

  // ----------------------------------------------
  // Input side
  // ----------------------------------------------
  ddr_capture i_ddr_capture (
    .ddr_clk_i ( ddr_clk_i ),
    .rst_ni    ( rst_ni    ),
    .ddr_i     ( ddr_i     ),
    .rx_byte_o ( rx_byte   )
  );

  frame_receiver #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_frame_receiver (
    .ddr_clk_i      ( ddr_clk_i    ),
    .rst_ni         ( rst_ni       ),
    .rx_byte_i      ( rx_byte      ),
    .credit_rcvd_o  ( credit_rcvd  ),
    .frame_popped_o ( frame_popped ),
    .rx             ( rx_stream    )
  );

  // ----------------------------------------------
  // Output side
  // ----------------------------------------------
  frame_transmitter #(
    .INIT_CREDITS ( INIT_CREDITS )
  ) i_frame_transmitter (
    .ddr_clk_i      ( ddr_clk_i    ),
    .rst_ni         ( rst_ni       ),
    .tx_valid_i     ( tx_valid_i   ),
    .tx_payload_i   ( tx_payload   ),
    .tx_ready_o     ( tx_ready_o   ),
    .credit_rcvd_i  ( credit_rcvd  ),
    .frame_popped_i ( frame_popped ),
    .ddr_o          ( ddr_o        )
  );

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source for the serial link.
// Drives the link clock and holds the active-low reset for a few cycles.
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- sim/tb_serial_link.sv
// Loopback testbench for the serial link. Frames from the case file go out on
// the DDR pins, come back through the receiver and are checked in order.
`timescale 1ns/100ps

module tb_serial_link;

  import serial_link_pkg::*;

  localparam int    FIFO_DEPTH   = 4;
  localparam int    INIT_CREDITS = 3;
  localparam string CASES_FILE   = "sim/link_cases.txt";
  localparam int    FRAME_CYCLES = BYTES_PER_FRAME + 1;
  // Owed credits leave one per idle cycle, then about five cycles round the loop
  localparam int    CREDIT_SETTLE_CYCLES = INIT_CREDITS + 6;

  logic        ddr_clk;
  logic        rst_n;
  logic        tx_valid;
  tag_e        tx_tag;
  logic [63:0] tx_data;
  logic        tx_ready;
  logic        rx_valid;
  logic        rx_ready;
  tag_e        rx_tag;
  logic [63:0] rx_data;
  logic [3:0]  ddr_out;
  logic [3:0]  ddr_in;

  string       case_name[$];
  bit          case_stall[$];
  tag_e        case_tag[$];
  logic [63:0] case_data[$];
  int          n_cases;
  bit          cases_loaded;
  bit          stall_hold;
  int          n_accepted;
  int          n_received;
  int          drv_pass;
  int          drv_fail;
  int          rx_pass;
  int          rx_fail;

  tb_clock_gen #(
    .PERIOD_NS    ( 8 ),
    .RESET_CYCLES ( 2 )
  ) i_clock_gen (
    .clk_o  ( ddr_clk ),
    .rst_no ( rst_n   )
  );

  // Short wire delay so each capture edge sees the settled phase
  assign #1 ddr_in = ddr_out;

  serial_link #(
    .FIFO_DEPTH   ( FIFO_DEPTH   ),
    .INIT_CREDITS ( INIT_CREDITS )
  ) DUT (
    .ddr_clk_i  ( ddr_clk  ),
    .rst_ni     ( rst_n    ),
    .tx_valid_i ( tx_valid ),
    .tx_tag_i   ( tx_tag   ),
    .tx_data_i  ( tx_data  ),
    .tx_ready_o ( tx_ready ),
    .rx_valid_o ( rx_valid ),
    .rx_ready_i ( rx_ready ),
    .rx_tag_o   ( rx_tag   ),
    .rx_data_o  ( rx_data  ),
    .ddr_i      ( ddr_in   ),
    .ddr_o      ( ddr_out  )
  );

  // --------------------------------------------------
  // Case file and compare tasks
  // --------------------------------------------------
  function automatic bit load_cases();
    int              fd;
    int              n;
    string           line;
    logic [8*32-1:0] name_buf;
    logic [8*8-1:0]  mode_buf;
    logic [7:0]      tag_raw;
    logic [63:0]     data_raw;

    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", CASES_FILE);
      return 1'b0;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %s %h %h", name_buf, mode_buf, tag_raw, data_raw);
      if (n == 4) begin
        case_name.push_back(string'(name_buf));
        case_stall.push_back(string'(mode_buf) == "stall");
        case_tag.push_back(tag_e'(tag_raw));
        case_data.push_back(data_raw);
      end else if (n > 0) begin
        $display("malformed line in %s: %s", CASES_FILE, line);
        $fclose(fd);
        return 1'b0;
      end
    end
    $fclose(fd);
    n_cases = case_name.size();
    return n_cases > 0;
  endfunction

  task automatic check_tag(input string name, input tag_e expected, input tag_e actual,
                           output bit ok);
    ok = (expected == actual);
    if (!ok) begin
      $display("FAILED %s: tag expected %02h actual %02h", name, expected, actual);
    end
  endtask

  task automatic check_data(input string name, input logic [63:0] expected,
                            input logic [63:0] actual, output bit ok);
    ok = (expected === actual);
    if (!ok) begin
      $display("FAILED %s: data expected %016h actual %016h", name, expected, actual);
    end
  endtask

  task automatic check_pulse_count(input string name, input int expected, input int actual,
                                   output bit ok);
    ok = (expected == actual);
    if (!ok) begin
      $display("FAILED %s: tx_ready_o pulses expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // --------------------------------------------------
  // Driver
  // --------------------------------------------------
  task automatic start_frame(input int idx);
    tx_valid <= 1'b1;
    tx_tag   <= case_tag[idx];
    tx_data  <= case_data[idx];
  endtask

  // Returns on the rising edge that completes the transfer
  task automatic wait_accept();
    do begin
      @(negedge ddr_clk);
    end while (!tx_ready);
    @(posedge ddr_clk);
    n_accepted++;
  endtask

  task automatic drain_link();
    tx_valid <= 1'b0;
    while (n_received != n_accepted) begin
      @(posedge ddr_clk);
    end
    repeat (CREDIT_SETTLE_CYCLES) @(posedge ddr_clk);
  endtask

  task automatic run_stall_group(inout int idx);
    int last;
    int pulses;
    bit ok;

    last = idx;
    while (last + 1 < n_cases && case_stall[last + 1]) begin
      last++;
    end
    drain_link();
    stall_hold <= 1'b1;
    while (rx_ready) begin
      @(posedge ddr_clk);
    end
    pulses = 0;
    while (idx <= last && pulses < INIT_CREDITS) begin
      start_frame(idx);
      wait_accept();
      pulses++;
      idx++;
    end
    if (idx <= last) begin
      // No credit left, so this frame has to wait for the release
      start_frame(idx);
      repeat (20 * FRAME_CYCLES) begin
        @(negedge ddr_clk);
        if (tx_ready) begin
          pulses++;
        end
      end
      check_pulse_count("stall_credit_limit", INIT_CREDITS, pulses, ok);
      if (ok) begin
        drv_pass++;
        $display("ok     stall_credit_limit");
      end else begin
        drv_fail++;
      end
      @(posedge ddr_clk);
      stall_hold <= 1'b0;
      wait_accept();
      idx++;
    end
    stall_hold <= 1'b0;
    while (idx <= last) begin
      start_frame(idx);
      wait_accept();
      idx++;
    end
  endtask

  initial begin : main
    int idx;
    int total_fail;

    tx_valid     = 1'b0;
    tx_tag       = Idle;
    tx_data      = '0;
    stall_hold   = 1'b0;
    n_accepted   = 0;
    drv_pass     = 0;
    drv_fail     = 0;
    cases_loaded = 1'b0;
    if (!load_cases()) begin
      $display("no usable test cases were read from %s", CASES_FILE);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      cases_loaded = 1'b1;
      @(posedge rst_n);
      @(posedge ddr_clk);
      idx = 0;
      while (idx < n_cases) begin
        if (case_stall[idx]) begin
          run_stall_group(idx);
        end else begin
          start_frame(idx);
          wait_accept();
          idx++;
        end
      end
      drain_link();
      // Quiet period where rx_valid_o must stay low
      repeat (4 * FRAME_CYCLES) @(posedge ddr_clk);
      total_fail = drv_fail + rx_fail;
      $display("%0d tests passed, %0d failed", drv_pass + rx_pass, total_fail);
      if (total_fail == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

  // --------------------------------------------------
  // Receiver and watchdog
  // --------------------------------------------------
  initial begin : receiver
    bit tag_ok;
    bit data_ok;

    rx_ready   = 1'b1;
    n_received = 0;
    rx_pass    = 0;
    rx_fail    = 0;
    forever begin
      @(posedge ddr_clk);
      rx_ready <= !stall_hold;
      @(negedge ddr_clk);
      if (rx_valid) begin
        if (n_received >= n_accepted) begin
          $display("rx_valid_o went high at %0t with no frame pending", $time);
          rx_fail++;
        end else if (rx_ready) begin
          check_tag(case_name[n_received], case_tag[n_received], rx_tag, tag_ok);
          check_data(case_name[n_received], case_data[n_received], rx_data, data_ok);
          if (tag_ok && data_ok) begin
            rx_pass++;
            $display("ok     %s", case_name[n_received]);
          end else begin
            rx_fail++;
          end
          n_received++;
        end
      end
    end
  end

  initial begin : watchdog
    int limit;

    wait (cases_loaded);
    limit = n_cases * FRAME_CYCLES * 8 + 200;
    repeat (limit) @(posedge ddr_clk);
    if (n_received < n_cases) begin
      $display("timeout: test %s never completed", case_name[n_received]);
    end else begin
      $display("timeout: the run did not finish after all frames arrived");
    end
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- sim/link_cases.txt
# name mode tag data
# mode is normal, or stall to hold rx_ready_i low; tag and data in hex
aw_walking_ones     normal 01 8040201008040201
w_all_ones          normal 02 ffffffffffffffff
ar_all_bit7         normal 03 8080808080808080
r_alternate_ff_80   normal 04 ff80ff80ff80ff80
aw_alternate_80_ff  normal 01 80ff80ff80ff80ff
w_byte_index        normal 02 0706050403020100
ar_low_byte_ff      normal 03 00000000000000ff
r_high_byte_80      normal 04 8000000000000000
aw_zero_data        normal 01 0000000000000000
stall_aw            stall  01 0123456789abcdef
stall_w             stall  02 fedcba9876543210
stall_ar            stall  03 a5a5a5a55a5a5a5a
stall_r_held        stall  04 ff00ff00ff00ff00
stall_aw_held       stall  01 80808080ffffffff
after_stall_w       normal 02 13579bdf2468ace0
after_stall_r       normal 04 7f7f7f7f80808080

//--- all.f
design/serial_link_pkg.sv
design/payload_stream_if.sv
design/ddr_capture.sv
design/frame_receiver.sv
design/frame_transmitter.sv
design/serial_link.sv
sim/tb_clock_gen.sv
sim/tb_serial_link.sv

//--- Makefile
# Verilator build and run of the serial link loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_link
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)
